// ==== files.f ====
verilog/lc3b_l2_pkg.sv
verilog/l2_plru_array.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache_control.sv
verilog/l2_cache.sv
verilog/l2_evict_buffer.sv
verilog/l2_subsystem.sv
sim/l2_mem_model.sv
sim/l2_cache_tb.sv

// ==== sim/l2_cache_tb.sv ====
`timescale 1ns/10ps

module l2_cache_tb;

localparam int NUM_SETS = 8;

logic                       clk = 1'b0;
logic                       rst;
logic                       mem_read;
logic                       mem_write;
lc3b_l2_pkg::lc3b_line_mask mem_byte_enable;
lc3b_l2_pkg::lc3b_line      mem_wdata;
lc3b_l2_pkg::lc3b_word      mem_address;
logic                       mem_resp;
lc3b_l2_pkg::lc3b_line      mem_rdata;
logic                       pmem_resp;
lc3b_l2_pkg::lc3b_line      pmem_rdata;
logic                       pmem_read;
logic                       pmem_write;
lc3b_l2_pkg::lc3b_word      pmem_address;
lc3b_l2_pkg::lc3b_line      pmem_wdata;
lc3b_l2_pkg::lc3b_word      l2_miss_counter;
logic                       l2_dirty_evict;
int                         write_count;
lc3b_l2_pkg::lc3b_word      last_waddr;
lc3b_l2_pkg::lc3b_line      last_wdata;

// CPU-visible memory contents, keyed by line address.
lc3b_l2_pkg::lc3b_line shadow [logic [11:0]];
lc3b_l2_pkg::lc3b_line expect_line;
lc3b_l2_pkg::lc3b_word read_resp_count;
int                    dirty_evicts;
logic [31:0]           rng = 32'he8cb1517;
logic                  req_first;
logic                  check_hit;
logic                  timed_out = 1'b0;
logic                  run_done = 1'b0;
int                    errors = 0;
int                    test_errors = 0;
int                    tests_run = 0;

always #20 clk = ~clk;

l2_subsystem #(.NUM_SETS(NUM_SETS)) dut_i
(
    .clk(clk),
    .rst(rst),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_byte_enable(mem_byte_enable),
    .mem_wdata(mem_wdata),
    .mem_address(mem_address),
    .mem_resp(mem_resp),
    .mem_rdata(mem_rdata),
    .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata),
    .l2_miss_counter(l2_miss_counter),
    .l2_dirty_evict(l2_dirty_evict)
);

l2_mem_model mem_i
(
    .clk(clk),
    .rst(rst),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata),
    .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata),
    .write_count(write_count),
    .last_waddr(last_waddr),
    .last_wdata(last_wdata)
);

task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
endtask

task automatic finish_test(input string name);
    $display("%s: %0d errors", name, errors - test_errors);
    test_errors = errors;
    tests_run++;
endtask

task automatic give_up(input string what);
    $display("timed out after 200 cycles waiting for %s", what);
    timed_out = 1'b1;
    forever @(posedge clk);
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
endfunction

function automatic lc3b_l2_pkg::lc3b_line random_line();
    lc3b_l2_pkg::lc3b_line line;
    for (int k = 0; k < 4; k++)
        line[32*k +: 32] = next_random();
    return line;
endfunction

function automatic lc3b_l2_pkg::lc3b_line initial_line(input logic [11:0] line_addr);
    lc3b_l2_pkg::lc3b_line line;
    for (int b = 0; b < 16; b++)
        line[8*b +: 8] = 8'(line_addr * 7 + b);
    return line;
endfunction

function automatic lc3b_l2_pkg::lc3b_line shadow_line(input logic [11:0] line_addr);
    return shadow.exists(line_addr) ? shadow[line_addr] : initial_line(line_addr);
endfunction

// Byte address of the line with this tag in this set.
function automatic lc3b_l2_pkg::lc3b_word line_address(input int tag, input int set);
    return lc3b_l2_pkg::lc3b_word'((tag * NUM_SETS + set) * 16);
endfunction

task automatic cpu_access(input logic write, input lc3b_l2_pkg::lc3b_word addr,
                          input lc3b_l2_pkg::lc3b_line wdata,
                          input lc3b_l2_pkg::lc3b_line_mask mask, input logic hit_expected);
    lc3b_l2_pkg::lc3b_line line;
    int n;
    line = shadow_line(addr[15:4]);
    if (write)
    begin
        for (int b = 0; b < 16; b++)
            if (mask[b])
                line[8*b +: 8] = wdata[8*b +: 8];
        shadow[addr[15:4]] = line;
    end
    expect_line = line;
    check_hit = hit_expected;
    mem_address = addr;
    mem_wdata = wdata;
    mem_byte_enable = mask;
    mem_read = !write;
    mem_write = write;
    req_first = 1'b1;
    @(posedge clk);
    #2;
    req_first = 1'b0;
    n = 0;
    while (!mem_resp && n < 200)
    begin
        @(posedge clk);
        #2;
        n++;
    end
    if (!mem_resp)
        give_up("mem_resp");
    // Hold the request through the edge that sees mem_resp.
    @(posedge clk);
    #2;
    mem_read = 1'b0;
    mem_write = 1'b0;
    check_hit = 1'b0;
endtask

task automatic wait_for_writeback(input int writes_before);
    for (int n = 0; n < 200; n++)
    begin
        @(posedge clk);
        if (write_count != writes_before)
            break;
    end
    #2;
    if (write_count == writes_before)
        give_up("a memory write");
endtask

always @(posedge clk)
begin
    if (rst)
    begin
        read_resp_count <= 16'd0;
        dirty_evicts <= 0;
    end
    else
    begin
        if (pmem_read && pmem_resp)
            read_resp_count <= read_resp_count + 16'd1;
        if (l2_dirty_evict)
            dirty_evicts <= dirty_evicts + 1;
    end
end

read_data_a: assert property (@(posedge clk) disable iff (rst)
    (mem_resp && mem_read) |-> (mem_rdata == expect_line))
    else report_error("read data differs from shadow memory");

hit_latency_a: assert property (@(posedge clk) disable iff (rst)
    (req_first && check_hit) |=> !mem_resp ##1 mem_resp)
    else report_error("hit mem_resp not two edges after request");

counter_matches_a: assert property (@(posedge clk) disable iff (rst)
    l2_miss_counter == read_resp_count)
    else report_error("miss counter differs from memory read responses");

pmem_exclusive_a: assert property (@(posedge clk) disable iff (rst)
    !(pmem_read && pmem_write))
    else report_error("pmem_read and pmem_write high together");

initial
begin
    lc3b_l2_pkg::lc3b_word misses;
    lc3b_l2_pkg::lc3b_word a_addr;
    logic [31:0]           r;
    int                    evicts;
    int                    writes;
    rst = 1'b1;
    mem_read = 1'b0;
    mem_write = 1'b0;
    mem_byte_enable = '0;
    mem_wdata = '0;
    mem_address = '0;
    expect_line = '0;
    req_first = 1'b0;
    check_hit = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    assert (!mem_resp && !pmem_read && !pmem_write && l2_miss_counter == 16'd0)
        else report_error("outputs not idle after reset");
    finish_test("reset state");

    misses = l2_miss_counter;
    cpu_access(1'b0, line_address(20, 1), '0, '0, 1'b0);
    assert (l2_miss_counter == misses + 16'd1)
        else report_error("read miss did not add one to the miss counter");
    misses = l2_miss_counter;
    cpu_access(1'b0, line_address(20, 1), '0, '0, 1'b1);
    assert (l2_miss_counter == misses)
        else report_error("read hit changed the miss counter");
    finish_test("read miss then hit");

    cpu_access(1'b1, line_address(20, 1) + 16'd4, random_line(), 16'h5a3c, 1'b1);
    cpu_access(1'b0, line_address(20, 1), '0, '0, 1'b1);
    finish_test("masked write");

    // A goes to way 0, then B, C, D leave the tree pointing back at it.
    a_addr = line_address(1, 5);
    evicts = dirty_evicts;
    writes = write_count;
    cpu_access(1'b1, a_addr, random_line(), 16'hf00f, 1'b0);
    cpu_access(1'b0, line_address(2, 5), '0, '0, 1'b0);
    cpu_access(1'b0, line_address(3, 5), '0, '0, 1'b0);
    cpu_access(1'b0, line_address(4, 5), '0, '0, 1'b0);
    cpu_access(1'b0, line_address(5, 5), '0, '0, 1'b0);
    wait_for_writeback(writes);
    assert (dirty_evicts == evicts + 1)
        else report_error("l2_dirty_evict did not pulse once");
    assert (write_count == writes + 1 && last_waddr == a_addr)
        else report_error("victim written to the wrong address");
    assert (last_wdata == shadow_line(a_addr[15:4]))
        else report_error("victim data differs from shadow memory");
    cpu_access(1'b0, a_addr, '0, '0, 1'b0);
    finish_test("dirty eviction");

    for (int i = 0; i < 60; i++)
    begin
        r = next_random();
        cpu_access(r[20], line_address(int'(r % 6), 6 + int'(r[8])) + 16'(r[15:12]),
                   random_line(), lc3b_l2_pkg::lc3b_line_mask'(next_random()), 1'b0);
    end
    assert (l2_miss_counter == read_resp_count)
        else report_error("miss counter differs from memory read responses");
    finish_test("random traffic");
    run_done = 1'b1;
end

initial
begin
    wait (run_done || timed_out);
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (!timed_out && errors == 0)
        $display("Test passed");
    else
        $display("Test failed");
    $finish;
end

endmodule : l2_cache_tb

// ==== sim/l2_mem_model.sv ====
`timescale 1ns/10ps

module l2_mem_model
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pmem_read,
    input  logic                  pmem_write,
    input  lc3b_l2_pkg::lc3b_word pmem_address,
    input  lc3b_l2_pkg::lc3b_line pmem_wdata,
    output logic                  pmem_resp,
    output lc3b_l2_pkg::lc3b_line pmem_rdata,
    output int                    write_count,
    output lc3b_l2_pkg::lc3b_word last_waddr,
    output lc3b_l2_pkg::lc3b_line last_wdata
);

lc3b_l2_pkg::lc3b_line mem [4096];
logic [31:0]           rng;
int                    countdown;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Byte b of line L holds the low byte of L*7+b.
function automatic lc3b_l2_pkg::lc3b_line initial_line(input logic [11:0] line_addr);
    lc3b_l2_pkg::lc3b_line line;
    for (int b = 0; b < 16; b++)
        line[8*b +: 8] = 8'(line_addr * 7 + b);
    return line;
endfunction

initial
begin
    for (int l = 0; l < 4096; l++)
        mem[l] = initial_line(12'(l));
    rng = 32'he8cb1517;
    countdown = 0;
    pmem_resp = 1'b0;
    pmem_rdata = '0;
    write_count = 0;
    last_waddr = '0;
    last_wdata = '0;
    forever
    begin
        @(posedge clk);
        #2;
        if (pmem_resp || rst)
        begin
            pmem_resp = 1'b0;
            countdown = 0;
        end
        else if (pmem_read || pmem_write)
        begin
            // A new request draws a delay of 1 to 6 cycles.
            if (countdown == 0)
            begin
                rng = xorshift32(rng);
                countdown = 1 + int'(rng % 6);
            end
            countdown--;
            if (countdown == 0)
            begin
                if (pmem_read)
                    pmem_rdata = mem[pmem_address[15:4]];
                else
                begin
                    mem[pmem_address[15:4]] = pmem_wdata;
                    last_waddr = pmem_address;
                    last_wdata = pmem_wdata;
                    write_count++;
                end
                pmem_resp = 1'b1;
            end
        end
    end
end

endmodule : l2_mem_model

// ==== verilog/l2_cache.sv ====
`timescale 1ns/10ps

module l2_cache #(
    parameter int NUM_SETS = 8
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  lc3b_l2_pkg::lc3b_line_mask mem_byte_enable,
    input  lc3b_l2_pkg::lc3b_line      mem_wdata,
    input  lc3b_l2_pkg::lc3b_word      mem_address,
    input  logic                       pmem_resp,
    input  lc3b_l2_pkg::lc3b_line      pmem_rdata,
    input  logic                       ewb_empty,
    output logic                       mem_resp,
    output lc3b_l2_pkg::lc3b_line      mem_rdata,
    output logic                       pmem_read,
    output lc3b_l2_pkg::lc3b_word      pmem_address,
    output logic                       ld_ewb_buff,
    output logic                       l2_dirty_evict,
    output lc3b_l2_pkg::l2_evict_t     ewb_entry,
    output lc3b_l2_pkg::lc3b_word      l2_miss_counter
);

localparam int SET_W = $clog2(NUM_SETS);

lc3b_l2_pkg::l2_addr_t req_addr;
logic [SET_W-1:0]      set_index;
logic                  hit;
logic [1:0]            hit_way;
logic [1:0]            lru_way;
logic [1:0]            sel_way;
logic [3:0]            way_valid;
logic [3:0]            way_dirty;
logic                  ld_line;
logic                  ld_write;
logic                  clr_dirty;
logic                  ld_lru;

assign req_addr = mem_address;
assign set_index = req_addr.line_addr[SET_W-1:0];
assign pmem_address = {req_addr.line_addr, 4'h0};

// Counts line reads completed by memory.
always_ff @(posedge clk)
begin
    if (rst)
        l2_miss_counter <= 16'd0;
    else if (pmem_read && pmem_resp)
        l2_miss_counter <= l2_miss_counter + 16'd1;
end

l2_cache_datapath #(.NUM_SETS(NUM_SETS)) datapath_i
(
    .clk(clk),
    .rst(rst),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata),
    .mem_byte_enable(mem_byte_enable),
    .pmem_rdata(pmem_rdata),
    .ld_line(ld_line),
    .ld_write(ld_write),
    .clr_dirty(clr_dirty),
    .sel_way(sel_way),
    .hit(hit),
    .hit_way(hit_way),
    .way_valid(way_valid),
    .way_dirty(way_dirty),
    .victim(ewb_entry),
    .mem_rdata(mem_rdata)
);

l2_plru_array #(.NUM_SETS(NUM_SETS)) plru_i
(
    .clk(clk),
    .rst(rst),
    .set_index(set_index),
    .ld_lru(ld_lru),
    .touch_way(sel_way),
    .lru_way(lru_way)
);

l2_cache_control control_i
(
    .clk(clk),
    .rst(rst),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .hit(hit),
    .hit_way(hit_way),
    .lru_way(lru_way),
    .way_valid(way_valid),
    .way_dirty(way_dirty),
    .pmem_resp(pmem_resp),
    .ewb_empty(ewb_empty),
    .mem_resp(mem_resp),
    .pmem_read(pmem_read),
    .ld_line(ld_line),
    .ld_write(ld_write),
    .clr_dirty(clr_dirty),
    .ld_lru(ld_lru),
    .ld_ewb_buff(ld_ewb_buff),
    .l2_dirty_evict(l2_dirty_evict),
    .sel_way(sel_way)
);

endmodule : l2_cache

// ==== verilog/l2_cache_control.sv ====
`timescale 1ns/10ps

module l2_cache_control
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       hit,
    input  logic [1:0] hit_way,
    input  logic [1:0] lru_way,
    input  logic [3:0] way_valid,
    input  logic [3:0] way_dirty,
    input  logic       pmem_resp,
    input  logic       ewb_empty,
    output logic       mem_resp,
    output logic       pmem_read,
    output logic       ld_line,
    output logic       ld_write,
    output logic       clr_dirty,
    output logic       ld_lru,
    output logic       ld_ewb_buff,
    output logic       l2_dirty_evict,
    output logic [1:0] sel_way
);

typedef enum logic [2:0]
{
    s_idle,
    s_hit_resp,
    s_wait_buf,
    s_evict,
    s_fetch,
    s_fill
} state_t;

state_t     state;
state_t     state_next;
logic [1:0] victim_way;
logic       respond;

// Invalid ways are filled first, lowest index wins.
always_comb
begin
    victim_way = lru_way;
    for (int w = 3; w >= 0; w--)
        if (!way_valid[w])
            victim_way = w[1:0];
end

always_comb
begin
    state_next = state;
    case (state)
        s_idle:
            if (mem_read || mem_write)
                state_next = hit ? s_hit_resp : s_wait_buf;
        s_hit_resp:
            if (mem_resp)
                state_next = s_idle;
        s_wait_buf:
            if (ewb_empty)
            begin
                if (way_valid[victim_way] && way_dirty[victim_way])
                    state_next = s_evict;
                else
                    state_next = s_fetch;
            end
        s_evict:
            state_next = s_fetch;
        s_fetch:
            if (pmem_resp)
                state_next = s_fill;
        s_fill:
            state_next = s_hit_resp;
        default:
            state_next = s_idle;
    endcase
end

// First cycle of the hit state does the work; the second holds mem_resp.
assign respond = (state == s_hit_resp) && !mem_resp;
assign ld_write = respond && mem_write;
assign ld_lru = respond;

assign ld_ewb_buff = (state == s_evict);
assign l2_dirty_evict = (state == s_evict);
assign pmem_read = (state == s_fetch);
assign ld_line = pmem_read && pmem_resp;
assign clr_dirty = ld_line;
assign sel_way = (state == s_hit_resp) ? hit_way : victim_way;

always_ff @(posedge clk)
begin
    if (rst)
    begin
        state <= s_idle;
        mem_resp <= 1'b0;
    end
    else
    begin
        state <= state_next;
        mem_resp <= respond;
    end
end

single_resp_a: assert property (@(posedge clk) disable iff (rst) mem_resp |=> !mem_resp);

endmodule : l2_cache_control

// ==== verilog/l2_cache_datapath.sv ====
`timescale 1ns/10ps

module l2_cache_datapath #(
    parameter int NUM_SETS = 8
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  lc3b_l2_pkg::lc3b_word      mem_address,
    input  lc3b_l2_pkg::lc3b_line      mem_wdata,
    input  lc3b_l2_pkg::lc3b_line_mask mem_byte_enable,
    input  lc3b_l2_pkg::lc3b_line      pmem_rdata,
    input  logic                       ld_line,
    input  logic                       ld_write,
    input  logic                       clr_dirty,
    input  logic [1:0]                 sel_way,
    output logic                       hit,
    output logic [1:0]                 hit_way,
    output logic [3:0]                 way_valid,
    output logic [3:0]                 way_dirty,
    output lc3b_l2_pkg::l2_evict_t     victim,
    output lc3b_l2_pkg::lc3b_line      mem_rdata
);

localparam int SET_W = $clog2(NUM_SETS);
localparam int TAG_W = lc3b_l2_pkg::LINE_ADDR_W - SET_W;

lc3b_l2_pkg::l2_addr_t addr;
logic [SET_W-1:0]      set_index;
logic [TAG_W-1:0]      tag;
logic [TAG_W-1:0]      tag_arr [4][NUM_SETS];
lc3b_l2_pkg::lc3b_line data_arr [4][NUM_SETS];
logic [3:0]            valid_arr [NUM_SETS];
logic [3:0]            dirty_arr [NUM_SETS];
logic [3:0]            hit_vec;
lc3b_l2_pkg::lc3b_line merged;

assign addr = mem_address;
assign set_index = addr.line_addr[SET_W-1:0];
assign tag = addr.line_addr[lc3b_l2_pkg::LINE_ADDR_W-1:SET_W];

assign way_valid = valid_arr[set_index];
assign way_dirty = dirty_arr[set_index];

always_comb
begin
    for (int w = 0; w < 4; w++)
        hit_vec[w] = valid_arr[set_index][w] && (tag_arr[w][set_index] == tag);
end

always_comb
begin
    hit_way = 2'd0;
    for (int w = 3; w >= 0; w--)
        if (hit_vec[w])
            hit_way = w[1:0];
end

assign hit = |hit_vec;
assign mem_rdata = data_arr[hit_way][set_index];

// Byte-masked merge of the CPU data into the selected line.
always_comb
begin
    merged = data_arr[sel_way][set_index];
    for (int b = 0; b < lc3b_l2_pkg::LINE_BYTES; b++)
        if (mem_byte_enable[b])
            merged[8*b +: 8] = mem_wdata[8*b +: 8];
end

assign victim.address = {tag_arr[sel_way][set_index], set_index, 4'h0};
assign victim.data = data_arr[sel_way][set_index];

always_ff @(posedge clk)
begin
    if (ld_line)
    begin
        tag_arr[sel_way][set_index] <= tag;
        data_arr[sel_way][set_index] <= pmem_rdata;
    end
    else if (ld_write)
        data_arr[sel_way][set_index] <= merged;
end

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int s = 0; s < NUM_SETS; s++)
        begin
            valid_arr[s] <= 4'b0000;
            dirty_arr[s] <= 4'b0000;
        end
    end
    else
    begin
        if (ld_line)
            valid_arr[set_index][sel_way] <= 1'b1;
        if (clr_dirty)
            dirty_arr[set_index][sel_way] <= 1'b0;
        else if (ld_write)
            dirty_arr[set_index][sel_way] <= 1'b1;
    end
end

one_hit_a: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule : l2_cache_datapath

// ==== verilog/l2_evict_buffer.sv ====
`timescale 1ns/10ps

module l2_evict_buffer
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ld_ewb_buff,
    input  lc3b_l2_pkg::l2_evict_t ewb_entry,
    input  logic                   pmem_read,
    input  logic                   pmem_resp,
    output logic                   ewb_empty,
    output logic                   pmem_write,
    output lc3b_l2_pkg::lc3b_word  pmem_waddress,
    output lc3b_l2_pkg::lc3b_line  pmem_wdata
);

logic                   full;
lc3b_l2_pkg::l2_evict_t entry;

assign ewb_empty = !full;

// Line reads from the cache take the port first.
assign pmem_write = full && !pmem_read;
assign pmem_waddress = entry.address;
assign pmem_wdata = entry.data;

always_ff @(posedge clk)
begin
    if (ld_ewb_buff)
        entry <= ewb_entry;
end

always_ff @(posedge clk)
begin
    if (rst)
        full <= 1'b0;
    else if (ld_ewb_buff)
        full <= 1'b1;
    else if (pmem_write && pmem_resp)
        full <= 1'b0;
end

// The cache holds every miss until the buffer has drained.
load_when_empty_a: assert property (@(posedge clk) disable iff (rst)
    ld_ewb_buff |-> ewb_empty);

endmodule : l2_evict_buffer

// ==== verilog/l2_plru_array.sv ====
`timescale 1ns/10ps

module l2_plru_array #(
    parameter int NUM_SETS = 8
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(NUM_SETS)-1:0] set_index,
    input  logic                        ld_lru,
    input  logic [1:0]                  touch_way,
    output logic [1:0]                  lru_way
);

// Bit 0 is the root, bit 1 the left pair, bit 2 the right pair.
logic [2:0] tree [NUM_SETS];
logic [2:0] cur;

assign cur = tree[set_index];
assign lru_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

always_ff @(posedge clk)
begin
    if (rst)
    begin
        for (int s = 0; s < NUM_SETS; s++)
            tree[s] <= 3'b000;
    end
    else if (ld_lru)
    begin
        // Point away from the touched way.
        tree[set_index][0] <= ~touch_way[1];
        if (touch_way[1])
            tree[set_index][2] <= ~touch_way[0];
        else
            tree[set_index][1] <= ~touch_way[0];
    end
end

no_touch_in_reset_a: assert property (@(posedge clk) rst |-> (ld_lru !== 1'b1));

endmodule : l2_plru_array

// ==== verilog/l2_subsystem.sv ====
`timescale 1ns/10ps

module l2_subsystem #(
    parameter int NUM_SETS = 8
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  lc3b_l2_pkg::lc3b_line_mask mem_byte_enable,
    input  lc3b_l2_pkg::lc3b_line      mem_wdata,
    input  lc3b_l2_pkg::lc3b_word      mem_address,
    output logic                       mem_resp,
    output lc3b_l2_pkg::lc3b_line      mem_rdata,
    input  logic                       pmem_resp,
    input  lc3b_l2_pkg::lc3b_line      pmem_rdata,
    output logic                       pmem_read,
    output logic                       pmem_write,
    output lc3b_l2_pkg::lc3b_word      pmem_address,
    output lc3b_l2_pkg::lc3b_line      pmem_wdata,
    output lc3b_l2_pkg::lc3b_word      l2_miss_counter,
    output logic                       l2_dirty_evict
);

lc3b_l2_pkg::lc3b_word  cache_paddr;
lc3b_l2_pkg::lc3b_word  ewb_waddr;
lc3b_l2_pkg::l2_evict_t ewb_entry;
logic                   ld_ewb_buff;
logic                   ewb_empty;
logic                   cache_resp;
logic                   ewb_resp;

assign pmem_address = pmem_read ? cache_paddr : ewb_waddr;
assign cache_resp = pmem_resp && pmem_read;
assign ewb_resp = pmem_resp && pmem_write;

l2_cache #(.NUM_SETS(NUM_SETS)) cache_i
(
    .clk(clk),
    .rst(rst),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_byte_enable(mem_byte_enable),
    .mem_wdata(mem_wdata),
    .mem_address(mem_address),
    .pmem_resp(cache_resp),
    .pmem_rdata(pmem_rdata),
    .ewb_empty(ewb_empty),
    .mem_resp(mem_resp),
    .mem_rdata(mem_rdata),
    .pmem_read(pmem_read),
    .pmem_address(cache_paddr),
    .ld_ewb_buff(ld_ewb_buff),
    .l2_dirty_evict(l2_dirty_evict),
    .ewb_entry(ewb_entry),
    .l2_miss_counter(l2_miss_counter)
);

l2_evict_buffer ewb_i
(
    .clk(clk),
    .rst(rst),
    .ld_ewb_buff(ld_ewb_buff),
    .ewb_entry(ewb_entry),
    .pmem_read(pmem_read),
    .pmem_resp(ewb_resp),
    .ewb_empty(ewb_empty),
    .pmem_write(pmem_write),
    .pmem_waddress(ewb_waddr),
    .pmem_wdata(pmem_wdata)
);

port_exclusive_a: assert property (@(posedge clk) disable iff (rst)
    !(pmem_read && pmem_write));

endmodule : l2_subsystem

// ==== verilog/lc3b_l2_pkg.sv ====
package lc3b_l2_pkg;

    // Bytes per cache line and width of a line address.
    localparam int LINE_BYTES  = 16;
    localparam int LINE_ADDR_W = 12;

    typedef logic [15:0] lc3b_word;

    // Eight words, byte 0 in the low bits.
    typedef logic [127:0] lc3b_line;

    typedef logic [LINE_BYTES-1:0] lc3b_line_mask;

    typedef struct packed
    {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [3:0]             offset;
    } l2_addr_t;

    // One dirty victim on its way to memory.
    typedef struct packed
    {
        lc3b_word address;
        lc3b_line data;
    } l2_evict_t;

endpackage : lc3b_l2_pkg
